/* hdl/aesRound_defines.svh */
/*
 * AES round unit constants
 * Sizes of the state and its bytes, shared by the package and the datapath
 */
`ifndef AES_ROUND_DEFINES_SVH
`define AES_ROUND_DEFINES_SVH

`define AES_STATE_SIZE 16 // Bytes in one state or round key
`define AES_BYTE_WIDTH 8  // Bits in one GF(2^8) element

// Columns in the 4x4 state, which is also its number of rows
`define AES_COLUMNS 4

`endif

/* hdl/AESDefinitions.sv */
/*
 * AES type definitions
 * Byte, state and round key types, the controller states and the xtime step
 */
`default_nettype none
`include "aesRound_defines.svh"

package AESDefinitions;

  typedef logic [`AES_BYTE_WIDTH-1:0] byte_t; // One GF(2^8) element

  // Byte i is row i mod 4, column i div 4, and byte 0 holds the top bits
  typedef byte_t [0:`AES_STATE_SIZE-1] state_t;
  typedef byte_t [0:`AES_STATE_SIZE-1] roundKey_t;

  typedef enum logic [1:0]
  {
    IDLE,
    BUSY,
    DONE
  } roundCtrlState_t;

  // Multiply by x in GF(2^8), reducing by the polynomial 11B
  function automatic byte_t xtime(input byte_t a);
    return {a[`AES_BYTE_WIDTH-2:0], 1'b0} ^ (a[`AES_BYTE_WIDTH-1] ? 8'h1b : 8'h00);
  endfunction

endpackage

`default_nettype wire

/* hdl/SubBytes.sv */
/*
 * SubBytes and InvSubBytes stage
 * Each byte goes through a computed S-box: the GF(2^8) inverse and the
 * affine map, in forward or inverse order
 */
`default_nettype none
`timescale 1ns/1ps
`include "aesRound_defines.svh"

module SubBytes (
  input  AESDefinitions::state_t in,
  input  logic                   inverse,
  output AESDefinitions::state_t out
);

  import AESDefinitions::*;

  // Shift and add product, each doubling reduced through xtime
  function automatic byte_t gfMul(input byte_t a, input byte_t b);
    byte_t acc;
    byte_t p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc ^= p;
      p = xtime(p);
    end
    return acc;
  endfunction

  // Inverse as a^254 by square and multiply; zero comes out as zero
  function automatic byte_t gfInv(input byte_t a);
    byte_t      r;
    byte_t      sq;
    logic [7:0] e;
    r  = 8'h01;
    sq = a;
    e  = 8'd254;
    for (int i = 0; i < 8; i++)
    begin
      if (e[i])
        r = gfMul(r, sq);
      sq = gfMul(sq, sq);
    end
    return r;
  endfunction

  function automatic byte_t rotl(input byte_t b, input int n);
    return byte_t'((b << n) | (b >> (8 - n)));
  endfunction

  function automatic byte_t affine(input byte_t b);
    return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ 8'h63;
  endfunction

  // Undoes the affine map, so InvSubBytes is this followed by the inverse
  function automatic byte_t affineInv(input byte_t b);
    return rotl(b, 1) ^ rotl(b, 3) ^ rotl(b, 6) ^ 8'h05;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `AES_STATE_SIZE; i++)
    begin
      if (inverse)
        out[i] = gfInv(affineInv(in[i]));
      else
        out[i] = affine(gfInv(in[i]));
    end
  end

endmodule

`default_nettype wire

/* hdl/MixColumns.sv */
/*
 * MixColumns and InvMixColumns stages
 * Column by column matrix products in GF(2^8), built from xtime and XOR
 */
`default_nettype none
`timescale 1ns/1ps
`include "aesRound_defines.svh"

// Circulant matrix with first row 2 3 1 1
module MixColumns (
  input  AESDefinitions::state_t in,
  output AESDefinitions::state_t out
);

  import AESDefinitions::*;

  state_t m2;
  state_t m3;

  always_comb
  begin
    for (int i = 0; i < `AES_STATE_SIZE; i++)
    begin
      m2[i] = xtime(in[i]);
      m3[i] = m2[i] ^ in[i]; // 3a is 2a plus a
    end
    for (int i = 0; i < `AES_STATE_SIZE; i += `AES_COLUMNS)
    begin
      out[i+0] = m2[i+0] ^ m3[i+1] ^ in[i+2] ^ in[i+3];
      out[i+1] = in[i+0] ^ m2[i+1] ^ m3[i+2] ^ in[i+3];
      out[i+2] = in[i+0] ^ in[i+1] ^ m2[i+2] ^ m3[i+3];
      out[i+3] = m3[i+0] ^ in[i+1] ^ in[i+2] ^ m2[i+3];
    end
  end

endmodule

// Circulant matrix with first row 14 11 13 9
module MixColumnsInverse (
  input  AESDefinitions::state_t in,
  output AESDefinitions::state_t out
);

  import AESDefinitions::*;

  state_t x2; // Each byte times 2, 4 and 8
  state_t x4;
  state_t x8;
  state_t m9;
  state_t m11;
  state_t m13;
  state_t m14;

  always_comb
  begin
    for (int i = 0; i < `AES_STATE_SIZE; i++)
    begin
      x2[i]  = xtime(in[i]);
      x4[i]  = xtime(x2[i]);
      x8[i]  = xtime(x4[i]);
      m9[i]  = x8[i] ^ in[i];
      m11[i] = x8[i] ^ x2[i] ^ in[i];
      m13[i] = x8[i] ^ x4[i] ^ in[i];
      m14[i] = x8[i] ^ x4[i] ^ x2[i];
    end
    for (int i = 0; i < `AES_STATE_SIZE; i += `AES_COLUMNS)
    begin
      out[i+0] = m14[i+0] ^ m11[i+1] ^ m13[i+2] ^ m9[i+3];
      out[i+1] = m9[i+0]  ^ m14[i+1] ^ m11[i+2] ^ m13[i+3];
      out[i+2] = m13[i+0] ^ m9[i+1]  ^ m14[i+2] ^ m11[i+3];
      out[i+3] = m11[i+0] ^ m13[i+1] ^ m9[i+2]  ^ m14[i+3];
    end
  end

endmodule

`default_nettype wire

/* hdl/AESRound.sv */
/*
 * AES round datapath
 * One encrypt or decrypt round, with the mix stage bypassed on the final round
 */
`default_nettype none
`timescale 1ns/1ps
`include "aesRound_defines.svh"

module AESRound (
  input  AESDefinitions::state_t    state,
  input  AESDefinitions::roundKey_t roundKey,
  input  logic                      decrypt,
  input  logic                      finalRound,
  output AESDefinitions::state_t    result
);

  import AESDefinitions::*;

  state_t subIn;
  state_t subOut;
  state_t shifted;   // ShiftRows of the substituted state
  state_t mixOut;
  state_t invMixIn;  // InvSubBytes output with the key already added
  state_t invMixOut;

  // Row r rotates by r bytes, left for encryption and right for decryption
  function automatic state_t rotateRows(input state_t s, input logic right);
    state_t o;
    int     row;
    int     col;
    int     src;
    for (int i = 0; i < `AES_STATE_SIZE; i++)
    begin
      row = i % `AES_COLUMNS; // The state is square, so rows and columns match
      col = i / `AES_COLUMNS;
      if (right)
        src = (col - row + `AES_COLUMNS) % `AES_COLUMNS;
      else
        src = (col + row) % `AES_COLUMNS;
      o[i] = s[row + `AES_COLUMNS * src];
    end
    return o;
  endfunction

  // SubBytes works bytewise, so InvShiftRows can go ahead of it on decrypt
  assign subIn    = decrypt ? rotateRows(state, 1'b1) : state;
  assign shifted  = rotateRows(subOut, 1'b0);
  assign invMixIn = subOut ^ roundKey;

  SubBytes SubBytes_inst (.in(subIn), .inverse(decrypt), .out(subOut));

  MixColumns MixColumns_inst (.in(shifted), .out(mixOut));

  MixColumnsInverse MixColumnsInverse_inst (.in(invMixIn), .out(invMixOut));

  always_comb
  begin
    if (decrypt)
      result = finalRound ? invMixIn : invMixOut;
    else
      result = (finalRound ? shifted : mixOut) ^ roundKey; // Key goes in last
  end

endmodule

`default_nettype wire

/* hdl/AESRoundUnit.sv */
/*
 * AES round unit
 * Four-phase req/ack wrapper around one combinational AES round, with the
 * request captured on accept and the result registered one cycle later
 */
`default_nettype none
`timescale 1ns/1ps
`include "aesRound_defines.svh"

module AESRoundUnit (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      req,
  input  logic                      decrypt,
  input  logic                      finalRound,
  input  AESDefinitions::state_t    stateIn,
  input  AESDefinitions::roundKey_t roundKey,
  output logic                      ack,
  output AESDefinitions::state_t    stateOut
);

  import AESDefinitions::*;

  roundCtrlState_t ctrlState;

  state_t    stateReg;
  roundKey_t keyReg;
  logic      decryptReg;
  logic      finalReg;
  state_t    roundResult;
  logic      accept;

  assign accept = (ctrlState == IDLE) && req;

  // Request copy that the datapath works on while the requester waits
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      stateReg   <= stateIn;
      keyReg     <= roundKey;
      decryptReg <= decrypt;
      finalReg   <= finalRound;
    end
  end

  AESRound AESRound_inst (
    .state      (stateReg),
    .roundKey   (keyReg),
    .decrypt    (decryptReg),
    .finalRound (finalReg),
    .result     (roundResult)
  );

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      ctrlState <= IDLE;
      ack       <= 1'b0;
      stateOut  <= '0;
    end
    else
    begin
      case (ctrlState)
        IDLE:
          if (accept)
            ctrlState <= BUSY;
        BUSY:
        begin
          stateOut  <= roundResult; // Holds until the next result
          ack       <= 1'b1;
          ctrlState <= DONE;
        end
        DONE:
          if (!req) // Stay here as long as the requester holds req
          begin
            ack       <= 1'b0;
            ctrlState <= IDLE;
          end
        default:
          ctrlState <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tests/AESRoundUnit_chk.sv */
/*
 * Handshake and data checks for the AES round unit, bound into its top level
 */
`default_nettype none
`timescale 1ns/1ps

module AESRoundUnit_chk (
  input logic                            clk,
  input logic                            arstN,
  input logic                            req,
  input logic                            ack,
  input AESDefinitions::state_t          stateIn,
  input AESDefinitions::roundKey_t       roundKey,
  input AESDefinitions::state_t          stateOut,
  input AESDefinitions::roundCtrlState_t ctrlState
);

  import AESDefinitions::*;

  int failCount = 0; // Failed assertions so far

  ackLowInReset: assert property (@(posedge clk) !arstN |-> !ack)
    else
    begin
      failCount++;
      $error("ack is high while reset is asserted");
    end

  // Accept edge, then one cycle in BUSY, then ack is seen high
  ackLatency: assert property (@(posedge clk) disable iff (!arstN)
    (ctrlState == IDLE && req) |=> !ack ##1 ack)
    else
    begin
      failCount++;
      $error("ack did not rise two cycles after the request was accepted");
    end

  ackHeldWhileReq: assert property (@(posedge clk) disable iff (!arstN)
    (ack && req) |=> ack)
    else
    begin
      failCount++;
      $error("ack fell while req was still high");
    end

  resultStable: assert property (@(posedge clk) disable iff (!arstN)
    ack |=> $stable(stateOut))
    else
    begin
      failCount++;
      $error("stateOut changed while ack was high");
    end

  knownRequestData: assert property (@(posedge clk)
    req |-> !$isunknown(stateIn) && !$isunknown(roundKey))
    else
    begin
      failCount++;
      $error("stateIn or roundKey is unknown while req is high");
    end

endmodule

bind AESRoundUnit AESRoundUnit_chk AESRoundUnit_chk_inst (
  .clk       (clk),
  .arstN     (arstN),
  .req       (req),
  .ack       (ack),
  .stateIn   (stateIn),
  .roundKey  (roundKey),
  .stateOut  (stateOut),
  .ctrlState (ctrlState)
);

`default_nettype wire

/* tests/AESRoundUnit_tb.sv */
/*
 * Testbench for the AES round unit
 * Four-phase requests in both directions, checked against a reference round
 */
`default_nettype none
`timescale 1ns/1ps
`include "aesRound_defines.svh"

module AESRoundUnit_tb;

  import AESDefinitions::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_TXNS   = 110; // Upper bound on the requests issued below

  logic      clk;
  logic      arstN;
  logic      req;
  logic      decrypt;
  logic      finalRound;
  state_t    stateIn;
  roundKey_t roundKey;
  logic      ack;
  state_t    stateOut;

  byte_t  sbox [256];
  byte_t  invSbox [256];
  integer seed = 32'h1b55;
  int     errors = 0;
  state_t expVal;
  state_t gotVal;
  event   resultReady;

  AESRoundUnit AESRoundUnit_inst (
    .clk        (clk),
    .arstN      (arstN),
    .req        (req),
    .decrypt    (decrypt),
    .finalRound (finalRound),
    .stateIn    (stateIn),
    .roundKey   (roundKey),
    .ack        (ack),
    .stateOut   (stateOut)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic state_t randomBlock();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // Product modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t gfProduct(input byte_t a, input byte_t b);
    byte_t acc;
    acc = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ a;
      a = a[7] ? ((a << 1) ^ 8'h1b) : (a << 1);
    end
    return acc;
  endfunction

  function automatic byte_t affineMap(input byte_t b);
    byte_t o;
    for (int i = 0; i < 8; i++)
      o[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    return o ^ 8'h63;
  endfunction

  task automatic buildSboxTables();
    byte_t inv;
    for (int x = 0; x < 256; x++)
    begin
      inv = 8'h00; // Zero has no inverse and stays zero
      for (int y = 1; y < 256; y++)
        if (gfProduct(byte_t'(x), byte_t'(y)) == 8'h01)
          inv = byte_t'(y);
      sbox[x] = affineMap(inv);
      invSbox[sbox[x]] = byte_t'(x); // The inverse S-box undoes the forward one
    end
  endtask

  function automatic state_t shiftRowsRef(input state_t s, input logic right);
    state_t o;
    int     r;
    int     c;
    for (int i = 0; i < `AES_STATE_SIZE; i++)
    begin
      r = i % 4;
      c = i / 4;
      o[i] = right ? s[r + 4 * ((c + 4 - r) % 4)] : s[r + 4 * ((c + r) % 4)];
    end
    return o;
  endfunction

  // Row r of the circulant matrix is the first row rotated right by r
  function automatic state_t mixRef(input state_t s, input logic inverse);
    byte_t  coef [4];
    state_t o;
    if (inverse)
      coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    else
      coef = '{8'h02, 8'h03, 8'h01, 8'h01};
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
      begin
        o[4 * c + r] = 8'h00;
        for (int k = 0; k < 4; k++)
          o[4 * c + r] ^= gfProduct(coef[(k - r + 4) % 4], s[4 * c + k]);
      end
    return o;
  endfunction

  function automatic state_t aesRoundRef(input state_t s, input roundKey_t k,
                                         input logic dec, input logic fin);
    state_t a;
    if (!dec)
    begin
      for (int i = 0; i < `AES_STATE_SIZE; i++)
        a[i] = sbox[s[i]];
      a = shiftRowsRef(a, 1'b0);
      if (!fin)
        a = mixRef(a, 1'b0);
      return a ^ k;
    end
    a = shiftRowsRef(s, 1'b1);
    for (int i = 0; i < `AES_STATE_SIZE; i++)
      a[i] = invSbox[a[i]];
    a = a ^ k; // Straight inverse cipher adds the key before InvMixColumns
    if (!fin)
      a = mixRef(a, 1'b1);
    return a;
  endfunction

  // One four-phase transfer, with req held for extra cycles after ack
  task automatic transact(input state_t s, input roundKey_t k, input logic dec,
                          input logic fin, input int hold, output state_t res);
    @(posedge clk);
    #1;
    stateIn    = s;
    roundKey   = k;
    decrypt    = dec;
    finalRound = fin;
    req        = 1'b1;
    while (!ack)
    begin
      @(posedge clk);
      #1;
    end
    res = stateOut;
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clk);
      #1;
      assert (ack === 1'b1 && stateOut === res)
      else
      begin
        errors++;
        $display("ERR stateOut in hold exp %h got %h, ack %h", res, stateOut, ack);
      end
    end
    req = 1'b0;
    while (ack)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic checkRound(input state_t s, input roundKey_t k, input logic dec,
                            input logic fin, input int hold, output state_t res);
    transact(s, k, dec, fin, hold, res);
    expVal = aesRoundRef(s, k, dec, fin);
    gotVal = res;
    -> resultReady;
  endtask

  always @(resultReady)
  begin
    assert (gotVal === expVal)
    else
    begin
      errors++;
      $display("ERR stateOut exp %h got %h", expVal, gotVal);
    end
  end

  initial
  begin
    state_t    s;
    roundKey_t k;
    state_t    res;
    state_t    res2;
    int        hold;
    arstN      = 1'b1;
    req        = 1'b1; // Raised inside reset, so the unit must ignore it
    decrypt    = 1'b0;
    finalRound = 1'b0;
    stateIn    = randomBlock();
    roundKey   = randomBlock();
    buildSboxTables();
    #1;
    arstN = 1'b0; // A clean falling edge after time zero resets the flops
    repeat (2) @(posedge clk);
    #1;
    req   = 1'b0;
    arstN = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    assert (ack === 1'b0 && stateOut === '0)
    else
    begin
      errors++;
      $display("ERR after reset ack %h stateOut %h", ack, stateOut);
    end

    // Round 1 of the FIPS-197 appendix B example
    s = 128'h193de3bea0f4e22b9ac68d2ae9f84808;
    k = 128'ha0fafe1788542cb123a339392a6c7605;
    checkRound(s, k, 1'b0, 1'b0, 0, res);
    assert (res === 128'ha49c7ff2689f352b6b5bea43026a5049)
    else
    begin
      errors++;
      $display("ERR stateOut exp %h got %h", 128'ha49c7ff2689f352b6b5bea43026a5049, res);
    end

    for (int i = 0; i < 50; i++)
      checkRound(randomBlock(), randomBlock(), 1'b1, 1'b0, 0, res);

    s = randomBlock();
    k = randomBlock();
    checkRound(s, k, 1'b0, 1'b0, 0, res);
    checkRound(res, k, 1'b1, 1'b0, 0, res2);

    for (int i = 0; i < 20; i++)
    begin
      checkRound(randomBlock(), randomBlock(), 1'b0, 1'b1, 0, res);
      checkRound(randomBlock(), randomBlock(), 1'b1, 1'b1, 0, res);
    end

    // With the key added back, a final decrypt round undoes a final encrypt round
    s = randomBlock();
    k = randomBlock();
    checkRound(s, k, 1'b0, 1'b1, 0, res);
    checkRound(res ^ k, '0, 1'b1, 1'b1, 0, res2);
    assert (res2 === s)
    else
    begin
      errors++;
      $display("ERR stateOut exp %h got %h", s, res2);
    end

    for (int i = 0; i < 10; i++)
    begin
      hold = {$random(seed)} % 11;
      checkRound(randomBlock(), randomBlock(), (i % 2) == 1, 1'b0, hold, res);
    end

    repeat (2) @(posedge clk);
    errors += AESRoundUnit_inst.AESRoundUnit_chk_inst.failCount; // Bound assertion failures
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Each request takes well under 20 cycles, even with the longest hold
  initial
  begin
    #(NUM_TXNS * 20 * CLK_PERIOD + 20 * CLK_PERIOD);
    errors += AESRoundUnit_inst.AESRoundUnit_chk_inst.failCount;
    $display("Timeout: the unit stopped completing requests");
    $display("Errors: %0d", errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/AESDefinitions.sv
hdl/SubBytes.sv
hdl/MixColumns.sv
hdl/AESRound.sv
hdl/AESRoundUnit.sv
tests/AESRoundUnit_chk.sv
tests/AESRoundUnit_tb.sv

/* Bender.yml */
package:
  name: aes_round_unit

export_include_dirs:
  - hdl

sources:
  - hdl/AESDefinitions.sv
  - hdl/SubBytes.sv
  - hdl/MixColumns.sv
  - hdl/AESRound.sv
  - hdl/AESRoundUnit.sv
  - target: test
    files:
      - tests/AESRoundUnit_chk.sv
      - tests/AESRoundUnit_tb.sv
